//--- isa_pkg.sv
package isa_pkg;

  typedef logic [63:0] word_t;
  typedef logic [31:0] inst_t;

  // Instruction field positions
  localparam int LIT_MSB      = 20;
  localparam int LIT_LSB      = 13;
  localparam int MEM_DISP_MSB = 15;
  localparam int BR_DISP_MSB  = 20;
  localparam int BR_FUNC_MSB  = 28;
  localparam int BR_FUNC_LSB  = 26;

  typedef enum logic [1:0] {
    OPA_REG      = 2'd0,
    OPA_MEM_DISP = 2'd1,
    OPA_NPC      = 2'd2,
    OPA_NOT3     = 2'd3
  } opa_sel_e;

  typedef enum logic [1:0] {
    OPB_REG     = 2'd0,
    OPB_LIT     = 2'd1,
    OPB_BR_DISP = 2'd2
  } opb_sel_e;

  typedef enum logic [3:0] {
    ADDQ, SUBQ, AND, BIC, BIS, ORNOT, XOR, EQV,
    SRL, SLL, SRA, CMPULT, CMPEQ, CMPULE, CMPLT, CMPLE
  } alu_func_e;

  // Low two bits of the branch function
  typedef enum logic [1:0] {
    LBC = 2'd0,
    EQ  = 2'd1,
    LT  = 2'd2,
    LE  = 2'd3
  } br_cond_e;

  function automatic word_t lit_value(inst_t inst);
    return word_t'(inst[LIT_MSB:LIT_LSB]); // zero-extended
  endfunction

  function automatic word_t mem_disp(inst_t inst);
    return {{(63 - MEM_DISP_MSB){inst[MEM_DISP_MSB]}}, inst[MEM_DISP_MSB:0]};
  endfunction

  // Word displacement, scaled to bytes
  function automatic word_t br_disp(inst_t inst);
    return {{(61 - BR_DISP_MSB){inst[BR_DISP_MSB]}}, inst[BR_DISP_MSB:0], 2'b00};
  endfunction

  function automatic logic [2:0] br_func(inst_t inst);
    return inst[BR_FUNC_MSB:BR_FUNC_LSB];
  endfunction

endpackage

//--- tag_pkg.sv
package tag_pkg;

  import isa_pkg::*;

  localparam int ROB_ENTRIES = 32;
  localparam int PR_ENTRIES  = 64;
  localparam int UNIT_COUNT  = 4; // alu, mult, branch 0, branch 1

  typedef logic [$clog2(ROB_ENTRIES)-1:0] rob_idx_t;
  typedef logic [$clog2(PR_ENTRIES)-1:0]  pr_idx_t;

  typedef struct packed {
    logic      valid;
    alu_func_e func;
    opa_sel_e  opa_sel;
    opb_sel_e  opb_sel;
    logic      cond_branch;
    logic      uncond_branch;
    inst_t     inst;
    word_t     npc;
    word_t     rs1_value;
    word_t     rs2_value;
    rob_idx_t  rob_idx;
    pr_idx_t   dest_pr;
  } issue_t;

  typedef struct packed {
    logic     done;
    word_t    result;
    rob_idx_t rob_idx;
    pr_idx_t  dest_pr;
  } comp_t;

  typedef struct packed {
    logic     valid;
    rob_idx_t rob_idx;
    word_t    target;
  } rollback_t;

  // Distances wrap modulo the ROB size
  function automatic logic is_younger(rob_idx_t op_idx, rob_idx_t br_idx, rob_idx_t head);
    rob_idx_t op_dist;
    rob_idx_t br_dist;
    op_dist = op_idx - head;
    br_dist = br_idx - head;
    return op_dist > br_dist;
  endfunction

  function automatic logic is_squashed(rob_idx_t op_idx, rollback_t rb, rob_idx_t head);
    return rb.valid && is_younger(op_idx, rb.rob_idx, head);
  endfunction

endpackage

//--- int_alu.sv
module int_alu
  import isa_pkg::*, tag_pkg::*;
(
  input  logic      clock,
  input  logic      reset,
  input  issue_t    issue,
  input  rollback_t rollback,
  input  rob_idx_t  rob_head,
  output comp_t     comp
);

  word_t opa;
  word_t opb;
  word_t result;
  logic  kill;

  // Unsigned compare, corrected when the signs differ
  function automatic logic signed_lt(word_t a, word_t b);
    if (a[63] == b[63]) begin
      return a < b;
    end
    return a[63];
  endfunction

  assign kill = is_squashed(issue.rob_idx, rollback, rob_head);

  always_comb begin
    case (issue.opa_sel)
      OPA_MEM_DISP: opa = mem_disp(issue.inst);
      default:      opa = issue.rs1_value;
    endcase
  end

  always_comb begin
    case (issue.opb_sel)
      OPB_LIT: opb = lit_value(issue.inst);
      default: opb = issue.rs2_value;
    endcase
  end

  always_comb begin
    result = '0;
    case (issue.func)
      ADDQ:   result = opa + opb;
      SUBQ:   result = opa - opb;
      AND:    result = opa & opb;
      BIC:    result = opa & ~opb;
      BIS:    result = opa | opb;
      ORNOT:  result = opa | ~opb;
      XOR:    result = opa ^ opb;
      EQV:    result = opa ^ ~opb;
      SRL:    result = opa >> opb[5:0];
      SLL:    result = opa << opb[5:0];
      SRA:    result = word_t'($signed(opa) >>> opb[5:0]);
      CMPULT: result = word_t'(opa < opb);
      CMPEQ:  result = word_t'(opa == opb);
      CMPULE: result = word_t'(opa <= opb);
      CMPLT:  result = word_t'(signed_lt(opa, opb));
      CMPLE:  result = word_t'(signed_lt(opa, opb) || opa == opb);
    endcase
  end

  always_ff @(posedge clock) begin
    comp.result  <= result;
    comp.rob_idx <= issue.rob_idx;
    comp.dest_pr <= issue.dest_pr;
    if (reset) begin
      comp.done <= 1'b0;
    end else begin
      comp.done <= issue.valid && !kill;
    end
  end

endmodule

//--- mult_stage.sv
module mult_stage
  import isa_pkg::*, tag_pkg::*;
#(
  parameter int MULT_STAGES = 4
) (
  input  logic      clock,
  input  logic      reset,
  input  logic      in_valid,
  input  word_t     product_in,
  input  word_t     mplier_in,
  input  word_t     mcand_in,
  input  rob_idx_t  tag_rob,
  input  pr_idx_t   tag_pr,
  input  rollback_t rollback,
  input  rob_idx_t  rob_head,
  output logic      out_valid,
  output word_t     product_out,
  output word_t     mplier_out,
  output word_t     mcand_out,
  output rob_idx_t  out_rob,
  output pr_idx_t   out_pr
);

  localparam int STEP = 64 / MULT_STAGES; // multiplier bits consumed per stage

  word_t partial;
  word_t next_product;
  word_t next_mplier;
  word_t next_mcand;
  logic  kill;

  assign partial      = word_t'(mplier_in[STEP-1:0]) * mcand_in;
  assign next_product = product_in + partial; // only the low word is kept
  assign next_mplier  = mplier_in >> STEP;
  assign next_mcand   = mcand_in << STEP;

  assign kill = is_squashed(tag_rob, rollback, rob_head);

  always_ff @(posedge clock) begin
    product_out <= next_product;
    mplier_out  <= next_mplier;
    mcand_out   <= next_mcand;
    out_rob     <= tag_rob;
    out_pr      <= tag_pr;
    if (reset) begin
      out_valid <= 1'b0;
    end else begin
      out_valid <= in_valid && !kill; // drop ops younger than the rollback
    end
  end

endmodule

//--- mult_pipe.sv
module mult_pipe
  import isa_pkg::*, tag_pkg::*;
#(
  parameter int MULT_STAGES = 4
) (
  input  logic      clock,
  input  logic      reset,
  input  issue_t    issue,
  input  rollback_t rollback,
  input  rob_idx_t  rob_head,
  output comp_t     comp
);

  // Entry 0 is the issue side, entry MULT_STAGES the last stage
  logic     [MULT_STAGES:0] valid_c;
  word_t    [MULT_STAGES:0] product_c;
  word_t    [MULT_STAGES:0] mplier_c;
  word_t    [MULT_STAGES:0] mcand_c;
  rob_idx_t [MULT_STAGES:0] rob_c;
  pr_idx_t  [MULT_STAGES:0] pr_c;

  assign valid_c[0]   = issue.valid;
  assign product_c[0] = '0;
  assign mplier_c[0]  = issue.rs1_value;
  assign mcand_c[0]   = (issue.opb_sel == OPB_LIT) ? lit_value(issue.inst) : issue.rs2_value;
  assign rob_c[0]     = issue.rob_idx;
  assign pr_c[0]      = issue.dest_pr;

  for (genvar i = 0; i < MULT_STAGES; i++) begin : g_stage
    mult_stage #(
      .MULT_STAGES(MULT_STAGES)
    ) stage_i (
      .clock      (clock),
      .reset      (reset),
      .in_valid   (valid_c[i]),
      .product_in (product_c[i]),
      .mplier_in  (mplier_c[i]),
      .mcand_in   (mcand_c[i]),
      .tag_rob    (rob_c[i]),
      .tag_pr     (pr_c[i]),
      .rollback   (rollback),
      .rob_head   (rob_head),
      .out_valid  (valid_c[i+1]),
      .product_out(product_c[i+1]),
      .mplier_out (mplier_c[i+1]),
      .mcand_out  (mcand_c[i+1]),
      .out_rob    (rob_c[i+1]),
      .out_pr     (pr_c[i+1])
    );
  end

  assign comp = '{done:    valid_c[MULT_STAGES],
                  result:  product_c[MULT_STAGES],
                  rob_idx: rob_c[MULT_STAGES],
                  dest_pr: pr_c[MULT_STAGES]};

endmodule

//--- branch_unit.sv
module branch_unit
  import isa_pkg::*, tag_pkg::*;
(
  input  logic      clock,
  input  logic      reset,
  input  issue_t    issue,
  input  rollback_t rollback,
  input  rob_idx_t  rob_head,
  output comp_t     comp,
  output rollback_t resolve
);

  logic [2:0] func;
  logic       cond_true;
  logic       kill;
  word_t      opa;
  word_t      opb;
  word_t      target;

  assign func = br_func(issue.inst);
  assign kill = is_squashed(issue.rob_idx, rollback, rob_head);

  always_comb begin
    case (br_cond_e'(func[1:0]))
      LBC:     cond_true = !issue.rs1_value[0];
      EQ:      cond_true = issue.rs1_value == '0;
      LT:      cond_true = issue.rs1_value[63];
      default: cond_true = issue.rs1_value[63] || issue.rs1_value == '0; // LE
    endcase
    if (func[2]) begin
      cond_true = !cond_true;
    end
  end

  // NPC plus displacement, or rs2 aligned to a word
  assign opa = (issue.opa_sel == OPA_NOT3) ? ~word_t'(3) : issue.npc;
  assign opb = (issue.opb_sel == OPB_BR_DISP) ? br_disp(issue.inst) : issue.rs2_value;

  always_comb begin
    case (issue.func)
      AND:     target = opa & opb;
      default: target = opa + opb;
    endcase
  end

  assign resolve.valid   = issue.valid && !kill &&
                           (issue.uncond_branch || (issue.cond_branch && cond_true));
  assign resolve.rob_idx = issue.rob_idx;
  assign resolve.target  = target;

  always_ff @(posedge clock) begin
    comp.result  <= target;
    comp.rob_idx <= issue.rob_idx;
    comp.dest_pr <= issue.dest_pr;
    if (reset) begin
      comp.done <= 1'b0;
    end else begin
      comp.done <= issue.valid && !kill;
    end
  end

endmodule

//--- rollback_ctrl.sv
module rollback_ctrl
  import tag_pkg::*;
(
  input  logic                  clock,
  input  logic                  reset,
  input  rollback_t [1:0]       resolve,
  input  rob_idx_t              rob_head,
  output rollback_t             rollback
);

  rollback_t pick;
  logic      take_second;

  // Second entry wins only when it sits closer to the head
  assign take_second = is_younger(resolve[0].rob_idx, resolve[1].rob_idx, rob_head);

  always_comb begin
    pick = '0; // idle record
    case ({resolve[1].valid, resolve[0].valid})
      2'b01: pick = resolve[0];
      2'b10: pick = resolve[1];
      2'b11: pick = take_second ? resolve[1] : resolve[0];
      default: pick = '0;
    endcase
  end

  always_ff @(posedge clock) begin
    rollback.rob_idx <= pick.rob_idx;
    rollback.target  <= pick.target;
    if (reset) begin
      rollback.valid <= 1'b0;
    end else begin
      rollback.valid <= pick.valid; // one cycle per resolved branch
    end
  end

endmodule

//--- exec_cluster.sv
module exec_cluster
  import tag_pkg::*;
#(
  parameter int MULT_STAGES = 4
) (
  input  logic                         clock,
  input  logic                         reset,
  input  issue_t                       alu_issue,
  input  issue_t                       mult_issue,
  input  issue_t    [1:0]              br_issue,
  input  rob_idx_t                     rob_head,
  output comp_t     [UNIT_COUNT-1:0]   comp,
  output rollback_t                    rollback
);

  rollback_t [1:0] resolve;

  int_alu alu_i (
    .clock   (clock),
    .reset   (reset),
    .issue   (alu_issue),
    .rollback(rollback),
    .rob_head(rob_head),
    .comp    (comp[0])
  );

  mult_pipe #(
    .MULT_STAGES(MULT_STAGES)
  ) mult_i (
    .clock   (clock),
    .reset   (reset),
    .issue   (mult_issue),
    .rollback(rollback),
    .rob_head(rob_head),
    .comp    (comp[1])
  );

  for (genvar b = 0; b < 2; b++) begin : g_br
    branch_unit br_i (
      .clock   (clock),
      .reset   (reset),
      .issue   (br_issue[b]),
      .rollback(rollback),
      .rob_head(rob_head),
      .comp    (comp[2+b]),
      .resolve (resolve[b])
    );
  end

  rollback_ctrl rb_i (
    .clock   (clock),
    .reset   (reset),
    .resolve (resolve),
    .rob_head(rob_head),
    .rollback(rollback)
  );

endmodule

//--- exec_cluster_tb.sv
module exec_cluster_tb
  import isa_pkg::*, tag_pkg::*;
();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int MULT_STAGES    = 4;
  localparam int ISSUE_CYCLES   = 2000;
  localparam int IDLE_CYCLES    = 2;
  localparam int ROB_LAG        = 12;
  localparam int TIMEOUT_CYCLES = ISSUE_CYCLES + MULT_STAGES + 2 + 94;

  typedef struct {
    int       unit;
    int       due;
    rob_idx_t rob_idx;
    pr_idx_t  dest_pr;
    word_t    result;
  } expect_t;

  logic                   clock;
  logic                   reset;
  issue_t                 alu_issue;
  issue_t                 mult_issue;
  issue_t    [1:0]        br_issue;
  rob_idx_t               rob_head;
  comp_t     [UNIT_COUNT-1:0] comp;
  rollback_t              rollback;

  expect_t   pending[$];
  rollback_t rb_model; // rollback register as predicted after the last edge
  rob_idx_t  next_rob;
  integer    seed;
  int        cycle = 0;
  int        checks = 0;
  int        errors = 0;

  exec_cluster #(
    .MULT_STAGES(MULT_STAGES)
  ) dut_i (
    .clock     (clock),
    .reset     (reset),
    .alu_issue (alu_issue),
    .mult_issue(mult_issue),
    .br_issue  (br_issue),
    .rob_head  (rob_head),
    .comp      (comp),
    .rollback  (rollback)
  );

  initial begin
    clock = 1'b0;
    forever #50 clock = ~clock;
  end

  always @(posedge clock) cycle <= cycle + 1;

  initial begin
    while (cycle < TIMEOUT_CYCLES) @(posedge clock);
    $display("Timeout after %0d cycles with %0d completions outstanding", cycle, pending.size());
    $display("FAIL: see errors above");
    $finish;
  end

  function automatic int head_dist(rob_idx_t idx, rob_idx_t head);
    return (int'(idx) - int'(head) + ROB_ENTRIES) % ROB_ENTRIES;
  endfunction

  function automatic logic dropped(rob_idx_t idx, rollback_t rb, rob_idx_t head);
    return rb.valid && (head_dist(idx, head) > head_dist(rb.rob_idx, head));
  endfunction

  function automatic word_t alu_model(issue_t p);
    word_t      a;
    word_t      b;
    logic [5:0] sh;
    a = (p.opa_sel == OPA_MEM_DISP) ? {{48{p.inst[15]}}, p.inst[15:0]} : p.rs1_value;
    b = (p.opb_sel == OPB_LIT) ? {56'd0, p.inst[20:13]} : p.rs2_value;
    sh = b[5:0];
    case (p.func)
      ADDQ:    return a + b;
      SUBQ:    return a - b;
      AND:     return a & b;
      BIC:     return a & ~b;
      BIS:     return a | b;
      ORNOT:   return a | ~b;
      XOR:     return a ^ b;
      EQV:     return ~(a ^ b);
      SRL:     return a >> sh;
      SLL:     return a << sh;
      SRA:     return word_t'($signed(a) >>> sh);
      CMPULT:  return {63'd0, a < b};
      CMPEQ:   return {63'd0, a == b};
      CMPULE:  return {63'd0, a <= b};
      CMPLT:   return {63'd0, $signed(a) < $signed(b)};
      default: return {63'd0, $signed(a) <= $signed(b)}; // CMPLE
    endcase
  endfunction

  function automatic word_t mult_model(issue_t p);
    word_t b;
    b = (p.opb_sel == OPB_LIT) ? {56'd0, p.inst[20:13]} : p.rs2_value;
    return p.rs1_value * b; // low half only
  endfunction

  function automatic logic br_taken(issue_t p);
    logic c;
    case (p.inst[27:26])
      2'd0:    c = !p.rs1_value[0];
      2'd1:    c = (p.rs1_value == 64'd0);
      2'd2:    c = p.rs1_value[63];
      default: c = p.rs1_value[63] || (p.rs1_value == 64'd0);
    endcase
    c = c ^ p.inst[28];
    return p.uncond_branch || (p.cond_branch && c);
  endfunction

  function automatic word_t br_target(issue_t p);
    if (p.opa_sel == OPA_NOT3) begin
      return p.rs2_value & ~64'd3;
    end
    return p.npc + {{41{p.inst[20]}}, p.inst[20:0], 2'b00};
  endfunction

  task automatic make_packet(input int unit, input logic active, output issue_t p);
    logic [31:0] r;
    r = $random(seed);
    p = '0;
    p.valid = r[0] && active;
    p.inst = $random(seed);
    p.npc = {$random(seed), $random(seed)};
    p.rs1_value = {$random(seed), $random(seed)};
    p.rs2_value = {$random(seed), $random(seed)};
    if (r[3:1] == 3'd0) p.rs2_value = p.rs1_value; // hits the equal compares
    p.dest_pr = pr_idx_t'($random(seed));
    if (unit < 2) begin
      p.func    = alu_func_e'(r[7:4]);
      p.opa_sel = r[8] ? OPA_MEM_DISP : OPA_REG;
      p.opb_sel = r[9] ? OPB_LIT : OPB_REG;
    end else begin
      if (r[4]) begin
        p.func    = AND; // register target
        p.opa_sel = OPA_NOT3;
        p.opb_sel = OPB_REG;
      end else begin
        p.func    = ADDQ;
        p.opa_sel = OPA_NPC;
        p.opb_sel = OPB_BR_DISP;
      end
      // Roughly one taken branch in eight
      p.uncond_branch = (r[8:5] == 4'd0);
      p.cond_branch   = (r[8:5] == 4'd1) || (r[8:5] == 4'd2);
      if (r[11:9] == 3'd0) p.rs1_value = '0;
    end
  endtask

  // Drives the packets for the next edge and predicts what that edge does
  task automatic drive_cycle(input logic active);
    issue_t    p[UNIT_COUNT];
    expect_t   kept[$];
    expect_t   e;
    rollback_t pick;
    rob_idx_t  head;
    int        first;
    int        u;
    head = next_rob - rob_idx_t'(ROB_LAG);
    for (int n = 0; n < UNIT_COUNT; n++) make_packet(n, active, p[n]);
    // Rotating start, so any unit may hold the oldest index of the cycle
    first = $unsigned($random(seed)) % UNIT_COUNT;
    for (int k = 0; k < UNIT_COUNT; k++) begin
      u = (first + k) % UNIT_COUNT;
      if (p[u].valid) begin
        p[u].rob_idx = next_rob;
        next_rob++;
      end
    end
    foreach (pending[i]) begin
      if (!dropped(pending[i].rob_idx, rb_model, head)) kept.push_back(pending[i]);
    end
    pending = kept;
    pick = '0;
    for (int n = 0; n < UNIT_COUNT; n++) begin
      if (p[n].valid && !dropped(p[n].rob_idx, rb_model, head)) begin
        e.unit    = n;
        e.due     = (n == 1) ? cycle + MULT_STAGES : cycle + 1;
        e.rob_idx = p[n].rob_idx;
        e.dest_pr = p[n].dest_pr;
        e.result  = (n == 0) ? alu_model(p[n]) : (n == 1) ? mult_model(p[n]) : br_target(p[n]);
        pending.push_back(e);
        if (n >= 2 && br_taken(p[n]) &&
            (!pick.valid || head_dist(p[n].rob_idx, head) < head_dist(pick.rob_idx, head))) begin
          pick.valid   = 1'b1;
          pick.rob_idx = p[n].rob_idx;
          pick.target  = e.result;
        end
      end
    end
    rb_model    = pick;
    alu_issue   = p[0];
    mult_issue  = p[1];
    br_issue[0] = p[2];
    br_issue[1] = p[3];
    rob_head    = head;
  endtask

  task automatic check_outputs();
    expect_t kept[$];
    expect_t e;
    logic    hit;
    for (int u = 0; u < UNIT_COUNT; u++) begin
      hit = 1'b0;
      foreach (pending[i]) begin
        if (pending[i].unit == u && pending[i].due == cycle) begin
          hit = 1'b1;
          e   = pending[i];
        end
      end
      checks++;
      assert (comp[u].done == hit) else begin
        errors++;
        $display("FAILED %0t ns: unit %0d done %0b, expected %0b", $time, u, comp[u].done, hit);
      end
      if (hit && comp[u].done) begin
        checks++;
        assert (comp[u].result == e.result && comp[u].rob_idx == e.rob_idx &&
                comp[u].dest_pr == e.dest_pr) else begin
          errors++;
          $display("FAILED %0t ns: unit %0d got %h rob %0d pr %0d, expected %h rob %0d pr %0d",
                   $time, u, comp[u].result, comp[u].rob_idx, comp[u].dest_pr,
                   e.result, e.rob_idx, e.dest_pr);
        end
      end
    end
    foreach (pending[i]) begin
      if (pending[i].due != cycle) kept.push_back(pending[i]);
    end
    pending = kept;
    checks++;
    assert (rollback.valid == rb_model.valid) else begin
      errors++;
      $display("FAILED %0t ns: rollback valid %0b, expected %0b", $time, rollback.valid,
               rb_model.valid);
    end
    if (rollback.valid && rb_model.valid) begin
      checks++;
      assert (rollback.rob_idx == rb_model.rob_idx && rollback.target == rb_model.target)
      else begin
        errors++;
        $display("FAILED %0t ns: rollback rob %0d target %h, expected rob %0d target %h", $time,
                 rollback.rob_idx, rollback.target, rb_model.rob_idx, rb_model.target);
      end
    end
  endtask

  initial begin
    seed       = 32'h6ed19055;
    next_rob   = '0;
    rb_model   = '0;
    reset      = 1'b1;
    alu_issue  = '0;
    mult_issue = '0;
    br_issue   = '0;
    rob_head   = '0;
    repeat (2) @(posedge clock);
    #10;
    reset = 1'b0;
    drive_cycle(1'b0);
    for (int n = 0; n < IDLE_CYCLES + ISSUE_CYCLES; n++) begin
      @(posedge clock);
      #10;
      check_outputs();
      drive_cycle(n >= IDLE_CYCLES - 1 && n < IDLE_CYCLES + ISSUE_CYCLES - 1);
    end
    // Drain whatever is still in flight
    while (pending.size() != 0 || rb_model.valid) begin
      @(posedge clock);
      #10;
      check_outputs();
      drive_cycle(1'b0);
    end
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

//--- exec_cluster.f
isa_pkg.sv
tag_pkg.sv
int_alu.sv
mult_stage.sv
mult_pipe.sv
branch_unit.sv
rollback_ctrl.sv
exec_cluster.sv
exec_cluster_tb.sv

//--- run.sh
#!/bin/sh
# Builds and runs the exec_cluster testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module exec_cluster_tb -f exec_cluster.f

./obj_dir/Vexec_cluster_tb | tee sim.log

if grep -q "^PASS: all tests$" sim.log; then
  echo "Simulation passed"
else
  echo "Simulation failed"
  exit 1
fi
